/* common/obj_cfg.svh */
// sprite controller sizes and limits
`ifndef OBJ_CFG_SVH
`define OBJ_CFG_SVH

`define OBJ_COUNT       128
`define OBJ_BYTES       8
`define OBJ_AW          10          // byte address into either RAM

// lines on which hs starts a scan
`define OBJ_LINE_FIRST  9'h10E
`define OBJ_LINE_LAST   9'h1F0

`define OBJ_HPOS_OFFSET 9'd9        // first column only

// sprites off, interrupts off
`define OBJ_CFG_RESET   8'h10

`endif

/* common/obj_pkg.sv */
// sprite controller types
package obj_pkg;

    typedef struct packed {
        logic        cs;
        logic        we;
        logic [10:0] addr;         // bit 10 selects the sprite table
        logic [7:0]  wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic [8:0] vdump;
        logic       hs;
        logic       lvbl;
        logic       pxl_cen;
    } video_t;

    typedef struct packed {
        logic [2:0] int_en;        // nmi, firq, irq
        logic       flip;
        logic       obj_dis;
        logic [2:0] sha_cfg;
        logic       vb_start_n;    // low while the copy engine works
    } obj_ctrl_t;

    typedef struct packed {
        logic [12:0] code;
        logic [7:0]  attr;
        logic        hflip;
        logic        vflip;
        logic [8:0]  hpos;
        logic [3:0]  ysub;
        logic [5:0]  hzoom;
        logic        hz_keep;      // not the first column
    } draw_req_t;

    typedef logic [2:0] obj_size_t;

    localparam logic [2:0] REG_CFG    = 3'd0;
    localparam logic [2:0] REG_SHA    = 3'd1;
    localparam logic [2:0] REG_ROM_L  = 3'd2;
    localparam logic [2:0] REG_ROM_H  = 3'd3;
    localparam logic [2:0] REG_ROM_VH = 3'd4;

endpackage

/* logic/obj_ram.sv */
// sprite byte RAM
`timescale 1ns/10ps
`include "obj_cfg.svh"

module obj_ram (
    input  logic               clk,
    input  logic [`OBJ_AW-1:0] addr0,
    input  logic [7:0]         wdata0,
    input  logic               we0,
    output logic [7:0]         q0,
    input  logic [`OBJ_AW-1:0] addr1,
    output logic [7:0]         q1
);
    logic [7:0] mem [0:(1<<`OBJ_AW)-1];

    always_ff @(posedge clk) begin
        if (we0) begin
            mem[addr0] <= wdata0;
        end
        q0 <= mem[addr0];       // old data on a write
        q1 <= mem[addr1];
    end

endmodule

/* logic/irq_edge.sv */
// edge triggered interrupt latch
`timescale 1ns/10ps

module irq_edge (
    input  logic clk,
    input  logic rst,
    input  logic event_in,
    input  logic en,
    output logic irq_n
);
    logic event_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            event_l <= 1'b0;
            irq_n   <= 1'b1;
        end else begin
            event_l <= event_in;
            if (!en) begin
                irq_n <= 1'b1;          // CPU acknowledges by clearing the enable
            end else if (event_in && !event_l) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

/* logic/obj_regs.sv */
// sprite control registers
`timescale 1ns/10ps
`include "obj_cfg.svh"

module obj_regs (
    input  logic               clk,
    input  logic               rst,
    input  obj_pkg::cpu_bus_t  bus,
    input  obj_pkg::video_t    video,
    input  logic [11:0]        pxl,
    output obj_pkg::obj_ctrl_t ctrl,
    output logic               shadow,
    output logic               irq_n,
    output logic               firq_n,
    output logic               nmi_n
);
    import obj_pkg::*;

    logic [7:0] mmr [0:4];
    logic       reg_we;

    // addresses 0 to 4 only, 5 to 7 are not mapped
    assign reg_we = bus.cs && bus.we && bus.addr[10:3] == 8'd0
                    && bus.addr[2:0] <= REG_ROM_VH;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mmr[REG_CFG]    <= `OBJ_CFG_RESET;
            mmr[REG_SHA]    <= 8'd0;
            mmr[REG_ROM_L]  <= 8'd0;
            mmr[REG_ROM_H]  <= 8'd0;
            mmr[REG_ROM_VH] <= 8'd0;
        end else if (reg_we) begin
            mmr[bus.addr[2:0]] <= bus.wdata;
        end
    end

    always_comb begin
        ctrl.int_en     = mmr[REG_CFG][2:0];
        ctrl.flip       = mmr[REG_CFG][3];
        ctrl.obj_dis    = mmr[REG_CFG][4];
        ctrl.sha_cfg    = mmr[REG_SHA][2:0];
        ctrl.vb_start_n = 1'b1;     // replaced by the copy engine status at the top
    end

    // shadow on palette marked pixels, sha_cfg[0] sets the polarity
    assign shadow = (&{pxl[11] | ctrl.sha_cfg[1], ~ctrl.sha_cfg[2], pxl[3:0]})
                    ^ ctrl.sha_cfg[0];

    irq_edge u_irq (
        .clk      (clk),
        .rst      (rst),
        .event_in (~video.lvbl),    // start of vertical blank
        .en       (ctrl.int_en[0]),
        .irq_n    (irq_n)
    );

    irq_edge u_firq (
        .clk      (clk),
        .rst      (rst),
        .event_in (video.vdump[0]), // every other line
        .en       (ctrl.int_en[1]),
        .irq_n    (firq_n)
    );

    irq_edge u_nmi (
        .clk      (clk),
        .rst      (rst),
        .event_in (video.vdump[4:0] == 5'd4),   // every 32 lines
        .en       (ctrl.int_en[2]),
        .irq_n    (nmi_n)
    );

endmodule

/* obj_dma/obj_dma.sv */
// vertical blank sprite copy
`timescale 1ns/10ps
`include "obj_cfg.svh"

module obj_dma (
    input  logic               clk,
    input  logic               rst,
    input  obj_pkg::video_t    video,
    input  logic               obj_dis,
    output logic [`OBJ_AW-1:0] table_addr,
    input  logic [7:0]         table_q,
    output logic [`OBJ_AW-1:0] copy_addr,
    output logic [7:0]         copy_wdata,
    output logic               copy_we,
    output logic               vb_start_n
);
    typedef enum logic [1:0] {IDLE, CLEAR, COPY, DONE} dma_state_t;

    dma_state_t         state;
    logic [`OBJ_AW:0]   cnt;        // top bit ends the copy pass
    logic [`OBJ_AW:0]   cnt_nx;
    logic [`OBJ_AW-4:0] prio;
    logic [`OBJ_AW-4:0] wr_prio;
    logic               lvbl_l;
    logic               dis_l;
    logic               tog;
    logic               step;
    logic               head;
    logic               skip;

    assign head    = cnt[2:0] == 3'd0;                  // byte 0 of a sprite
    assign skip    = state == COPY && head && !table_q[7];
    assign step    = video.pxl_cen && tog && !dis_l && !video.lvbl;
    assign wr_prio = head ? table_q[6:0] : prio;
    assign cnt_nx  = skip ? cnt + (`OBJ_AW+1)'(`OBJ_BYTES) : cnt + 1'b1;

    assign table_addr = cnt[`OBJ_AW-1:0];
    assign copy_addr  = state == CLEAR ? cnt[`OBJ_AW-1:0] : {wr_prio, cnt[2:0]};
    assign copy_wdata = state == CLEAR ? 8'd0 : table_q;
    assign copy_we    = step && (state == CLEAR || (state == COPY && !skip));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            cnt        <= '0;
            lvbl_l     <= 1'b0;
            dis_l      <= 1'b1;
            tog        <= 1'b0;
            vb_start_n <= 1'b0;
        end else begin
            lvbl_l <= video.lvbl;
            if (video.pxl_cen) begin
                tog <= ~tog;            // half the pixel rate
            end
            if (video.lvbl) begin
                state      <= IDLE;
                vb_start_n <= 1'b1;
            end else if (lvbl_l) begin
                state <= CLEAR;         // blank just began
                cnt   <= '0;
                dis_l <= obj_dis;
            end else if (step) begin
                vb_start_n <= state == DONE;
                case (state)
                    CLEAR: begin
                        cnt <= cnt + 1'b1;
                        if (&cnt[`OBJ_AW-1:0]) begin
                            cnt   <= '0;
                            state <= COPY;
                        end
                    end
                    COPY: begin
                        cnt <= cnt_nx;
                        if (cnt_nx[`OBJ_AW]) begin
                            state <= DONE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // slot of the sprite being copied
    always_ff @(posedge clk) begin
        if (step && state == COPY && head) begin
            prio <= table_q[6:0];
        end
    end

endmodule

/* obj_scan/obj_yzone.sv */
// vertical zoom and zone test
`timescale 1ns/10ps

module obj_yzone (
    input  logic               clk,
    input  logic               rst,
    input  logic [8:0]         y,
    input  logic [8:0]         vline,
    input  logic [5:0]         vzoom,
    input  obj_pkg::obj_size_t size,
    output logic [8:0]         ydiff,
    output logic               inzone,
    output logic [2:0]         last_col
);
    import obj_pkg::*;

    logic [8:0]  base;
    logic [5:0]  vzoom_1;
    obj_size_t   size_1;
    logic [17:0] prod;
    logic [8:0]  sum;
    logic        fits;

    assign prod = {vzoom_1, 3'b0} * base;
    assign sum  = base + prod[17:9];    // zoom stretches the row offset

    always_comb begin
        case (size_1)
            3'd0, 3'd1:       fits = base[8:4] == 5'd0 && sum[8:4] == 5'd0; // 16 lines
            3'd2, 3'd3, 3'd4: fits = base[8:5] == 4'd0 && sum[8:5] == 4'd0; // 32
            3'd5, 3'd6:       fits = base[8:6] == 3'd0 && sum[8:6] == 3'd0; // 64
            default:          fits = base[8:7] == 2'd0 && sum[8:7] == 2'd0; // 128
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base     <= '0;
            vzoom_1  <= '0;
            size_1   <= '0;
            ydiff    <= '0;
            inzone   <= 1'b0;
            last_col <= '0;
        end else begin
            base    <= y + vline;
            vzoom_1 <= vzoom;
            size_1  <= size;
            ydiff   <= sum;
            inzone  <= fits;
            case (size_1)
                3'd0, 3'd2:       last_col <= 3'd0;
                3'd1, 3'd3, 3'd5: last_col <= 3'd1;
                3'd4, 3'd6:       last_col <= 3'd3;
                default:          last_col <= 3'd7;
            endcase
        end
    end

endmodule

/* obj_scan/obj_scan.sv */
// sprite line scanner
`timescale 1ns/10ps
`include "obj_cfg.svh"

module obj_scan (
    input  logic               clk,
    input  logic               rst,
    input  obj_pkg::video_t    video,
    input  obj_pkg::obj_ctrl_t ctrl,
    output logic [`OBJ_AW-1:0] copy_addr,
    input  logic [7:0]         copy_q,
    output obj_pkg::draw_req_t req,
    output logic               dr_start,
    input  logic               dr_busy
);
    import obj_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_READ, S_ZONE, S_COL} scan_state_t;

    scan_state_t state;
    logic [6:0]  obj;
    logic [2:0]  sub;
    logic [2:0]  rd_sub;
    logic [2:0]  col;
    logic [2:0]  last_col;
    logic [2:0]  hcode;
    logic [2:0]  ccol;
    logic        rd_on;
    logic        hs_l;
    logic        busy_l;
    logic        line_go;
    logic        issue;
    logic        decide;
    logic        next_obj;
    logic        act;
    logic        inzone;
    logic [8:0]  vline;
    logic [8:0]  y;
    logic [8:0]  ydiff;
    obj_size_t   size;
    logic [12:0] code;
    logic [7:0]  attr;
    logic [7:0]  hpos_lo;
    logic [5:0]  vzoom;
    logic [5:0]  hzoom;
    logic        vflip;
    logic        hflip;
    logic        hpos_hi;

    assign line_go   = video.hs && !hs_l && video.vdump >= `OBJ_LINE_FIRST
                       && video.vdump <= `OBJ_LINE_LAST;
    assign issue     = state == S_COL && !dr_busy && !busy_l && !dr_start;
    assign decide    = state == S_ZONE && sub == 3'd1;     // zone result ready
    assign next_obj  = (decide && !(act && inzone)) || (issue && col == last_col);
    assign copy_addr = {obj, sub};
    assign hcode     = {code[4], code[2], code[0]};

    // column bits of the code
    always_comb begin
        case (size)
            3'd0, 3'd2:       ccol = hcode;
            3'd1, 3'd3, 3'd5: ccol = {hcode[2:1], col[0] ^ hflip};
            3'd4, 3'd6:       ccol = {hcode[2], col[1:0] ^ {2{hflip}}};
            default:          ccol = col ^ {3{hflip}};
        endcase
    end

    obj_yzone u_yzone (
        .clk      (clk),
        .rst      (rst),
        .y        (y),
        .vline    (vline),
        .vzoom    (vzoom),
        .size     (size),
        .ydiff    (ydiff),
        .inzone   (inzone),
        .last_col (last_col)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            obj      <= '0;
            sub      <= '0;
            col      <= '0;
            rd_on    <= 1'b0;
            hs_l     <= 1'b0;
            busy_l   <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            hs_l     <= video.hs;
            busy_l   <= dr_busy;
            rd_on    <= state == S_READ;
            dr_start <= issue;
            if (line_go) begin
                state <= S_READ;
                obj   <= '0;
                sub   <= '0;
            end else begin
                case (state)
                    S_READ: begin
                        sub <= sub + 1'b1;
                        if (sub == 3'd7) begin
                            state <= S_ZONE;
                        end
                    end
                    S_ZONE: begin
                        sub <= sub + 1'b1;
                        if (decide && act && inzone) begin
                            state <= S_COL;
                            col   <= '0;
                        end
                    end
                    S_COL: begin
                        if (issue) begin
                            col <= col + 1'b1;
                        end
                    end
                    default: ;
                endcase
                if (next_obj) begin
                    sub   <= '0;
                    obj   <= obj + 1'b1;
                    state <= obj == 7'(`OBJ_COUNT - 1) ? S_IDLE : S_READ;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_sub <= sub;
        if (line_go) begin
            vline <= video.vdump ^ {1'b0, {8{ctrl.flip}}};
        end
        if (rd_on) begin
            case (rd_sub)
                3'd0: act <= copy_q[7];
                3'd1: {size, code[12:8]} <= copy_q;
                3'd2: code[7:0] <= copy_q;
                3'd3: attr <= copy_q;
                3'd4: {vzoom, vflip, y[8]} <= copy_q;
                3'd5: y[7:0] <= copy_q;
                3'd6: {hzoom, hflip, hpos_hi} <= copy_q;
                default: hpos_lo <= copy_q;
            endcase
        end
        if (decide) begin
            // row bits into the code
            case (size)
                3'd2, 3'd3, 3'd4: code[1] <= ydiff[4] ^ vflip;
                3'd5, 3'd6:       {code[3], code[1]} <= ydiff[5:4] ^ {2{vflip}};
                3'd7:             {code[5], code[3], code[1]} <= ydiff[6:4] ^ {3{vflip}};
                default: ;
            endcase
        end
        if (issue) begin
            req.code    <= {code[12:5], ccol[2], code[3], ccol[1], code[1], ccol[0]};
            req.attr    <= attr;
            req.hflip   <= hflip;
            req.vflip   <= vflip;
            req.ysub    <= ydiff[3:0];
            req.hzoom   <= hzoom;
            req.hz_keep <= col != 3'd0;
            if (col == 3'd0) begin
                req.hpos <= {hpos_hi, hpos_lo} + `OBJ_HPOS_OFFSET;
            end else begin
                req.hpos <= req.hpos + 9'h10;   // next 16 pixel column
            end
        end
    end

endmodule

/* logic/obj_top.sv */
// sprite controller top
`timescale 1ns/10ps
`include "obj_cfg.svh"

module obj_top (
    input  logic               clk,
    input  logic               rst,
    input  obj_pkg::cpu_bus_t  bus,
    input  obj_pkg::video_t    video,
    output logic [7:0]         cpu_din,
    input  logic [11:0]        pxl,
    output logic               shadow,
    output obj_pkg::draw_req_t req,
    output logic               dr_start,
    input  logic               dr_busy,
    output logic               irq_n,
    output logic               firq_n,
    output logic               nmi_n
);
    import obj_pkg::*;

    obj_ctrl_t          reg_ctrl;
    obj_ctrl_t          scan_ctrl;
    logic               vb_start_n;
    logic               table_we;
    logic               reg_rd;
    logic [7:0]         cpu_q;
    logic [7:0]         table_q;
    logic [7:0]         copy_q;
    logic [7:0]         copy_wdata;
    logic [`OBJ_AW-1:0] table_addr;
    logic [`OBJ_AW-1:0] copy_waddr;
    logic [`OBJ_AW-1:0] copy_raddr;
    logic               copy_we;

    assign table_we = bus.cs && bus.we && bus.addr[10];
    assign reg_rd   = bus.cs && !bus.we && bus.addr == 11'd0;
    assign cpu_din  = reg_rd ? {7'd0, ~vb_start_n} : cpu_q;

    always_comb begin
        scan_ctrl            = reg_ctrl;
        scan_ctrl.vb_start_n = vb_start_n;
    end

    obj_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .video  (video),
        .pxl    (pxl),
        .ctrl   (reg_ctrl),
        .shadow (shadow),
        .irq_n  (irq_n),
        .firq_n (firq_n),
        .nmi_n  (nmi_n)
    );

    // CPU side table
    obj_ram u_table (
        .clk    (clk),
        .addr0  (bus.addr[`OBJ_AW-1:0]),
        .wdata0 (bus.wdata),
        .we0    (table_we),
        .q0     (cpu_q),
        .addr1  (table_addr),
        .q1     (table_q)
    );

    obj_dma u_dma (
        .clk        (clk),
        .rst        (rst),
        .video      (video),
        .obj_dis    (reg_ctrl.obj_dis),
        .table_addr (table_addr),
        .table_q    (table_q),
        .copy_addr  (copy_waddr),
        .copy_wdata (copy_wdata),
        .copy_we    (copy_we),
        .vb_start_n (vb_start_n)
    );

    // priority ordered copy read by the scanner
    obj_ram u_copy (
        .clk    (clk),
        .addr0  (copy_waddr),
        .wdata0 (copy_wdata),
        .we0    (copy_we),
        .q0     (),
        .addr1  (copy_raddr),
        .q1     (copy_q)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .video     (video),
        .ctrl      (scan_ctrl),
        .copy_addr (copy_raddr),
        .copy_q    (copy_q),
        .req       (req),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy)
    );

endmodule

/* test/tb_clkgen.sv */
// testbench clock and reset
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* test/obj_tb.sv */
// sprite controller testbench
`timescale 1ns/10ps
`include "obj_cfg.svh"

module obj_tb;
    import obj_pkg::*;

    localparam int LINE_CLKS   = 400;
    localparam int FRAME_LINES = 264;
    localparam int WATCH_NS    = 4 * FRAME_LINES * LINE_CLKS * 20 + 100000;

    logic        clk;
    logic        rst;
    cpu_bus_t    bus;
    video_t      video;
    logic [7:0]  cpu_din;
    logic [11:0] pxl;
    logic        shadow;
    draw_req_t   req;
    logic        dr_start;
    logic        dr_busy;
    logic        irq_n;
    logic        firq_n;
    logic        nmi_n;

    logic [7:0]  table_m [0:1023];  // what the CPU wrote
    logic [7:0]  copy_m [0:1023];   // expected copy buffer
    draw_req_t   exp_q [$];
    int          exp_idx;
    int          err_cnt;
    int          req_cnt;
    int          hcnt;
    int          busy_left;
    int          busy_len;
    int          i;
    logic [8:0]  next_line;
    logic [7:0]  cfg_reg;          // CFG as the DUT holds it
    logic        model_valid;
    logic        lvbl_q;
    logic        hs_q;
    logic [2:0]  ev1;
    logic [2:0]  ev2;
    logic [2:0]  en_d;
    logic [2:0]  irq_vec;          // nmi, firq, irq

    assign irq_vec = {nmi_n, firq_n, irq_n};

    tb_clkgen u_clkgen (.clk(clk), .rst(rst));

    obj_top dut (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .video    (video),
        .cpu_din  (cpu_din),
        .pxl      (pxl),
        .shadow   (shadow),
        .req      (req),
        .dr_start (dr_start),
        .dr_busy  (dr_busy),
        .irq_n    (irq_n),
        .firq_n   (firq_n),
        .nmi_n    (nmi_n)
    );

    task automatic report_error(input string msg);
        err_cnt++;
        $display("error %0t: %s", $time, msg);
    endtask

    // video timing, 400 clocks a line, hs at line start
    always @(posedge clk) begin
        if (rst) begin
            hcnt <= 0;
        end else begin
            video.pxl_cen <= ~video.pxl_cen;
            if (hcnt == LINE_CLKS - 1) begin
                hcnt         <= 0;
                next_line     = video.vdump == 9'h1FF ? 9'h0F8 : video.vdump + 9'd1;
                video.vdump <= next_line;
                video.lvbl  <= !(next_line >= 9'h0F8 && next_line <= 9'h10D);
                video.hs    <= 1'b1;
            end else begin
                hcnt <= hcnt + 1;
                if (hcnt == 15) begin
                    video.hs <= 1'b0;
                end
            end
        end
    end

    // pixel drawer stand-in
    always @(posedge clk) begin
        if (rst) begin
            busy_left <= 0;
            dr_busy   <= 1'b0;
        end else if (dr_start) begin
            busy_len = $urandom % 41;
            busy_left <= busy_len;
            dr_busy   <= busy_len != 0;
        end else if (busy_left > 0) begin
            busy_left <= busy_left - 1;
            dr_busy   <= busy_left > 1;
        end
    end

    // interrupt latches, bit order irq, firq, nmi
    always @(posedge clk) begin
        if (rst) begin
            ev1  <= '0;
            ev2  <= '0;
            en_d <= '0;
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (en_d[k] && ev1[k] && !ev2[k]) begin
                    assert (!irq_vec[k])
                        else report_error($sformatf("interrupt %0d did not fall", k));
                end
                if (!en_d[k]) begin
                    assert (irq_vec[k])
                        else report_error($sformatf("interrupt %0d low while disabled", k));
                end
            end
            ev1  <= {video.vdump[4:0] == 5'd4, video.vdump[0], !video.lvbl};
            ev2  <= ev1;
            en_d <= cfg_reg[2:0];
        end
    end

    task automatic copy_table();
        int p;
        for (int a = 0; a < 1024; a++) begin
            copy_m[a] = 8'd0;
        end
        for (int s = 0; s < `OBJ_COUNT; s++) begin
            if (table_m[s*8][7]) begin
                p = table_m[s*8][6:0];  // slot from the priority
                for (int k = 0; k < `OBJ_BYTES; k++) begin
                    copy_m[p*8+k] = table_m[s*8+k];
                end
            end
        end
    endtask

    // expected requests of one line, slot order
    task automatic build_line(input logic [8:0] vline);
        logic [7:0]  b [0:7];
        logic [8:0]  y;
        logic [8:0]  base;
        logic [8:0]  hpos;
        logic [2:0]  size;
        logic [2:0]  rows;
        logic [2:0]  cc;
        logic [2:0]  mask;
        logic [12:0] code;
        draw_req_t   r;
        int          height;
        int          ncols;
        exp_q.delete();
        exp_idx = 0;
        for (int s = 0; s < `OBJ_COUNT; s++) begin
            for (int k = 0; k < 8; k++) begin
                b[k] = copy_m[s*8+k];
            end
            size   = b[1][7:5];
            y      = {b[4][0], b[5]};
            base   = y + vline;
            height = size <= 1 ? 16 : size <= 4 ? 32 : size <= 6 ? 64 : 128;
            ncols  = (size == 0 || size == 2) ? 1 :
                     (size == 1 || size == 3 || size == 5) ? 2 :
                     (size == 4 || size == 6) ? 4 : 8;
            if (b[0][7] && base < height) begin
                code = {b[1][4:0], b[2]};
                rows = base[6:4] ^ {3{b[4][1]}};
                if (height >= 32) code[1] = rows[0];
                if (height >= 64) code[3] = rows[1];
                if (height == 128) code[5] = rows[2];
                hpos = {b[6][0], b[7]} + `OBJ_HPOS_OFFSET;
                mask = ncols - 1;
                for (int c = 0; c < ncols; c++) begin
                    cc = c;
                    if (b[6][1]) cc = cc ^ mask;
                    if (ncols >= 2) code[0] = cc[0];
                    if (ncols >= 4) code[2] = cc[1];
                    if (ncols == 8) code[4] = cc[2];
                    r.code    = code;
                    r.attr    = b[3];
                    r.hflip   = b[6][1];
                    r.vflip   = b[4][1];
                    r.hpos    = hpos + 16 * c;
                    r.ysub    = base[3:0];
                    r.hzoom   = b[6][7:2];
                    r.hz_keep = c != 0;
                    exp_q.push_back(r);
                end
            end
        end
    endtask

    // draw requests against the buffer model
    always @(posedge clk) begin
        if (!rst) begin
            assert (!(dr_start && dr_busy)) else report_error("draw request while busy");
            if (dr_start) begin
                req_cnt++;
                if (exp_idx >= exp_q.size()) begin
                    report_error($sformatf("unexpected draw request %h", req));
                end else begin
                    assert (req === exp_q[exp_idx])
                        else report_error($sformatf("request got %h expected %h",
                                                    req, exp_q[exp_idx]));
                    exp_idx++;
                end
            end
            if (!video.lvbl && lvbl_q && !cfg_reg[4]) begin
                copy_table();
                model_valid = 1'b1;
            end
            if (video.hs && !hs_q && model_valid && video.vdump >= `OBJ_LINE_FIRST
                && video.vdump <= `OBJ_LINE_LAST) begin
                assert (exp_idx == exp_q.size())
                    else report_error($sformatf("%0d of %0d requests on the line",
                                                exp_idx, exp_q.size()));
                build_line(video.vdump);
            end
        end
        lvbl_q <= video.lvbl;
        hs_q   <= video.hs;
    end

    task automatic cpu_write(input logic [10:0] addr, input logic [7:0] data);
        @(posedge clk);
        bus.cs    <= 1'b1;
        bus.we    <= 1'b1;
        bus.addr  <= addr;
        bus.wdata <= data;
        @(posedge clk);
        bus.cs <= 1'b0;
        bus.we <= 1'b0;
        if (addr == 11'd0) begin
            cfg_reg <= data;
        end
    endtask

    task automatic table_readback(input int a);
        @(posedge clk);
        bus.cs   <= 1'b1;
        bus.we   <= 1'b0;
        bus.addr <= 11'h400 + a;
        @(posedge clk);
        bus.cs <= 1'b0;
        @(posedge clk);
        assert (cpu_din === table_m[a])
            else report_error($sformatf("table %0d read %h", a, cpu_din));
    endtask

    task automatic status_check(input logic busy_bit);
        @(posedge clk);
        bus.cs   <= 1'b1;
        bus.we   <= 1'b0;
        bus.addr <= 11'd0;
        @(posedge clk);
        assert (cpu_din === {7'd0, busy_bit})
            else report_error($sformatf("status read %h", cpu_din));
        bus.cs <= 1'b0;
    endtask

    task automatic shadow_check();
        logic [11:0] p;
        logic [2:0]  s;
        logic        expect_sha;
        p = $urandom;
        if ($urandom % 2) p[3:0] = 4'hF;
        s = $urandom;
        @(posedge clk);
        pxl <= p;
        cpu_write({8'd0, REG_SHA}, {5'd0, s});
        @(posedge clk);
        expect_sha = (p[11] || s[1]) && !s[2] && p[3:0] == 4'hF;
        assert (shadow === (expect_sha ^ s[0]))
            else report_error($sformatf("shadow %b for pxl %h cfg %0d", shadow, p, s));
    endtask

    // active sprite starting at line first, vzoom zero
    task automatic place_sprite(input int idx, input logic [6:0] prio,
                                input logic [2:0] size, input logic [8:0] first);
        logic [8:0]  y;
        logic [31:0] r;
        y = 9'd0 - first;
        r = $urandom;
        table_m[idx*8+0] = {1'b1, prio};
        table_m[idx*8+1] = {size, r[4:0]};
        table_m[idx*8+4] = {6'd0, r[5], y[8]};
        table_m[idx*8+5] = y[7:0];
        table_m[idx*8+6] = r[15:8];
    endtask

    task automatic write_table();
        for (int a = 0; a < 1024; a++) begin
            cpu_write(11'h400 + a, table_m[a]);
        end
    endtask

    task automatic wait_line(input logic [8:0] line);
        @(posedge clk);
        while (video.vdump !== line) @(posedge clk);
    endtask

    initial begin
        #(WATCH_NS);
        $display("timeout: the run did not end within four frames");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h704062e9));
        bus         = '0;
        video.vdump = 9'h1F1;       // a few lines before the first blank
        video.hs    = 1'b0;
        video.lvbl  = 1'b1;
        video.pxl_cen = 1'b0;
        pxl         = '0;
        dr_busy     = 1'b0;
        cfg_reg     = `OBJ_CFG_RESET;
        model_valid = 1'b0;
        lvbl_q      = 1'b1;
        hs_q        = 1'b0;
        err_cnt     = 0;
        req_cnt     = 0;
        exp_idx     = 0;
        wait (!rst);
        for (i = 0; i < 1024; i++) begin
            table_m[i] = $urandom;
            if (i % 8 == 0) table_m[i][7] = 1'b0;
        end
        place_sprite(3, 7'd2, 3'd1, 9'h1B0);
        place_sprite(20, 7'd0, 3'd7, 9'h110);   // 8 columns
        place_sprite(50, 7'd4, 3'd2, 9'h1A0);
        place_sprite(77, 7'd1, 3'd4, 9'h190);
        place_sprite(120, 7'd3, 3'd5, 9'h1C0);
        write_table();
        for (i = 0; i < 16; i++) begin
            table_readback($urandom % 1024);
        end
        for (i = 0; i < 40; i++) begin
            shadow_check();
        end
        cpu_write({8'd0, REG_CFG}, 8'h07);      // sprites on, all interrupts
        wait_line(9'h0F9);
        status_check(1'b1);
        wait_line(9'h110);
        status_check(1'b0);
        wait_line(9'h1F8);
        wait_line(9'h120);
        cpu_write({8'd0, REG_CFG}, 8'h10);      // freeze the buffer
        for (i = 0; i < 1024; i++) begin
            table_m[i] = $urandom;
        end
        write_table();
        wait_line(9'h0F9);
        status_check(1'b0);
        wait_line(9'h1FA);
        assert (exp_idx == exp_q.size()) else report_error("requests missing on last line");
        assert (req_cnt > 0) else report_error("no draw requests seen");
        $display("checks done: %0d errors, %0d draw requests", err_cnt, req_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+common
common/obj_pkg.sv
logic/obj_ram.sv
logic/irq_edge.sv
logic/obj_regs.sv
obj_dma/obj_dma.sv
obj_scan/obj_yzone.sv
obj_scan/obj_scan.sv
logic/obj_top.sv
test/tb_clkgen.sv
test/obj_tb.sv
